// File: source/fanout_pkg.sv
package fanout_pkg;

    ////////////////////////////////////////
    // Command frames
    ////////////////////////////////////////

    localparam int FRAME_BITS = 8;                          // Bits per command frame
    localparam int FRAME_COUNT_BITS = $clog2(FRAME_BITS);   // Bit position within a frame
    localparam logic [2:0] FRAME_HEADER = 3'b110;           // Required top three bits
    localparam logic [FRAME_BITS-1:0] IDLE_FRAME = 8'b11000001;
    localparam int LOCK_BITS = 6;                           // Saturating lock counter

    localparam int NFANOUT = 4;
    localparam logic [NFANOUT-1:0] INVERT_MASK = 4'b0101;   // Set bit inverts that line

    ////////////////////////////////////////
    // Register port
    ////////////////////////////////////////

    localparam int REG_DATA_BITS = 32;
    localparam int REG_ADDR_BITS = 10;
    localparam int REG_BUFFER_BIT = 9;                      // 1 selects the capture buffer
    localparam int REG_INDEX_BITS = 2;
    localparam int REG_DELAY_BITS = 8;

    localparam logic [REG_INDEX_BITS-1:0] REG_CONTROL = 2'd0;
    localparam logic [REG_INDEX_BITS-1:0] REG_OFFSETS = 2'd1;
    localparam logic [REG_INDEX_BITS-1:0] REG_DELAY = 2'd2;
    localparam logic [REG_INDEX_BITS-1:0] REG_CLEAN_ENABLE = 2'd3;

    localparam logic [REG_DELAY_BITS-1:0] REG_DELAY_DEFAULT = 8'd100;
    localparam logic REG_CLEAN_ENABLE_DEFAULT = 1'b1;

    ////////////////////////////////////////
    // Capture buffer
    ////////////////////////////////////////

    localparam int CAPTURE_DEPTH = 256;
    localparam int CAPTURE_ADDR_BITS = 8;
    localparam int CAPTURE_WORD_BITS = 18;                  // Trigger, header error, raw, clean

    typedef enum logic [1:0] {
        FILLING,
        WAITING,
        READING
    } capture_state_t;

    typedef struct packed {
        logic [2:0] header;
        logic [3:0] payload;
        logic       stop;
    } frame_fields_t;

    typedef union packed {
        logic [FRAME_BITS-1:0] bits;
        frame_fields_t         fields;
    } frame_word_t;

endpackage

// File: source/frame_cleaner.sv
`timescale 1ns/1ps

module frame_cleaner
    import fanout_pkg::*;
(
    input  logic fast_clock_in,
    input  logic arstn,
    input  logic fast_command_in,
    input  logic clean_enable,
    output logic fast_command_out
);

    logic                        resync_command;  // Single resync stage
    logic [FRAME_BITS:0]         in_window;       // Top 8 bits form the candidate frame
    logic [FRAME_BITS:0]         out_shift;       // MSB drives the output
    logic [FRAME_COUNT_BITS-1:0] bit_count;       // Free running modulo 8
    logic [FRAME_COUNT_BITS-1:0] lock_pos;
    logic [LOCK_BITS-1:0]        lock_count;
    frame_word_t                 candidate;
    frame_word_t                 load_frame;
    logic                        header_match;
    logic                        at_lock;
    logic                        shifted_header;

    assign candidate.bits = in_window[FRAME_BITS:1];
    assign header_match = candidate.fields.header == FRAME_HEADER && candidate.fields.stop;
    assign at_lock = bit_count == lock_pos;

    // A header pattern one or two bits late marks a slipped frame
    assign shifted_header = in_window[FRAME_BITS-1 -: 3] == FRAME_HEADER
                         || in_window[FRAME_BITS-2 -: 3] == FRAME_HEADER;

    always_comb
    begin
        if (clean_enable && (!header_match || shifted_header))
            load_frame.bits = IDLE_FRAME;       // Damaged frame replaced
        else
            load_frame = candidate;
    end

    assign fast_command_out = out_shift[FRAME_BITS];

    ////////////////////////////////////////
    // Input resync and window
    ////////////////////////////////////////

    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            resync_command <= 1'b0;
            in_window <= '0;
        end
        else
        begin
            resync_command <= fast_command_in;
            in_window <= {in_window[FRAME_BITS-1:0], resync_command};
        end
    end

    ////////////////////////////////////////
    // Lock tracking and output frame
    ////////////////////////////////////////

    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            bit_count <= '0;
            lock_pos <= '0;
            lock_count <= '0;
            out_shift <= '0;
        end
        else
        begin
            bit_count <= bit_count + 1'b1;

            if (lock_count == '0)
            begin
                if (header_match)
                begin
                    lock_pos <= bit_count;      // First match sets the frame phase
                    lock_count <= 'd1;
                end
            end
            else if (at_lock)
            begin
                if (!header_match)
                    lock_count <= lock_count - 1'b1;
                else if (lock_count != '1)
                    lock_count <= lock_count + 1'b1;    // Saturates at 63
            end
            else if (header_match)
                lock_count <= lock_count - 1'b1;        // Match off phase

            if (at_lock)
                out_shift <= {out_shift[FRAME_BITS-1], load_frame.bits};
            else
                out_shift <= {out_shift[FRAME_BITS-1:0], 1'b0};
        end
    end

endmodule

// File: source/control_registers.sv
`timescale 1ns/1ps

module control_registers
    import fanout_pkg::*;
(
    input  logic                          fast_clock_in,
    input  logic                          arstn,
    input  logic [REG_ADDR_BITS-1:0]      reg_addr,
    input  logic                          reg_write,
    input  logic                          reg_read,
    input  logic [REG_DATA_BITS-1:0]      reg_wdata,
    output logic [REG_DATA_BITS-1:0]      reg_rdata,
    output logic                          reg_ack,
    input  capture_state_t                capture_state,
    input  logic [CAPTURE_WORD_BITS-1:0]  buffer_rdata,
    output logic                          clean_enable,
    output logic                          capture_restart,
    output logic [FRAME_COUNT_BITS-1:0]   raw_offset,
    output logic [FRAME_COUNT_BITS-1:0]   clean_offset,
    output logic [REG_DELAY_BITS-1:0]     post_delay
);

    logic                      reg_sel;         // Register range addressed
    logic [REG_INDEX_BITS-1:0] reg_index;
    logic [REG_DATA_BITS-1:0]  register_word;   // Read value of the addressed register
    logic [REG_DATA_BITS-1:0]  read_q;
    logic                      buffer_sel_q;    // Last read went to the buffer

    assign reg_sel = !reg_addr[REG_BUFFER_BIT];
    assign reg_index = reg_addr[REG_INDEX_BITS-1:0];

    always_comb
    begin
        register_word = '0;
        case (reg_index)
            REG_CONTROL:
            begin
                register_word[REG_DATA_BITS-1 -: 2] = capture_state;
                register_word[0] = capture_restart;
            end
            REG_OFFSETS:      register_word[2*FRAME_COUNT_BITS-1:0] = {clean_offset, raw_offset};
            REG_DELAY:        register_word[REG_DELAY_BITS-1:0] = post_delay;
            REG_CLEAN_ENABLE: register_word[0] = clean_enable;
        endcase
    end

    // Buffer data comes straight from the memory's read register
    assign reg_rdata = buffer_sel_q
                     ? {{(REG_DATA_BITS-CAPTURE_WORD_BITS){1'b0}}, buffer_rdata}
                     : read_q;

    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            reg_ack <= 1'b0;
            capture_restart <= 1'b0;
            raw_offset <= '0;
            clean_offset <= '0;
            post_delay <= REG_DELAY_DEFAULT;
            clean_enable <= REG_CLEAN_ENABLE_DEFAULT;
            read_q <= '0;
            buffer_sel_q <= 1'b0;
        end
        else
        begin
            reg_ack <= reg_write || reg_read;   // One cycle after the strobe
            capture_restart <= 1'b0;            // Held for one cycle only

            if (reg_write && reg_sel)
            begin
                case (reg_index)
                    REG_CONTROL: capture_restart <= reg_wdata[0];
                    REG_OFFSETS:
                    begin
                        raw_offset <= reg_wdata[FRAME_COUNT_BITS-1:0];
                        clean_offset <= reg_wdata[2*FRAME_COUNT_BITS-1 -: FRAME_COUNT_BITS];
                    end
                    REG_DELAY:        post_delay <= reg_wdata[REG_DELAY_BITS-1:0];
                    REG_CLEAN_ENABLE: clean_enable <= reg_wdata[0];
                endcase
            end

            if (reg_read)
            begin
                buffer_sel_q <= !reg_sel;
                read_q <= register_word;
            end
        end
    end

endmodule

// File: source/frame_capture.sv
`timescale 1ns/1ps

module frame_capture
    import fanout_pkg::*;
(
    input  logic                          fast_clock_in,
    input  logic                          arstn,
    input  logic                          capture_restart,
    input  logic                          fast_command_in,
    input  logic                          fast_command_out,
    input  logic [FRAME_COUNT_BITS-1:0]   raw_offset,
    input  logic [FRAME_COUNT_BITS-1:0]   clean_offset,
    input  logic [REG_DELAY_BITS-1:0]     post_delay,
    output capture_state_t                capture_state,
    output logic                          debug_trig,
    output logic                          write_enable,
    output logic [CAPTURE_ADDR_BITS-1:0]  write_addr,
    output logic [CAPTURE_WORD_BITS-1:0]  write_data
);

    logic [FRAME_BITS:0]         raw_window;
    logic [FRAME_BITS:0]         clean_window;
    logic [FRAME_COUNT_BITS-1:0] frame_count;   // Modulo 8
    frame_word_t                 raw_frame;
    frame_word_t                 clean_frame;
    frame_word_t                 raw_frame_q;
    frame_word_t                 clean_frame_q;
    logic                        raw_error_q;   // Latched raw header error
    logic [REG_DELAY_BITS-1:0]   wait_count;    // Frames since the trigger
    logic                        capture_rstn;

    assign raw_frame.bits = raw_window[FRAME_BITS:1];
    assign clean_frame.bits = clean_window[FRAME_BITS:1];
    assign capture_rstn = arstn && !capture_restart;

    assign write_enable = capture_state != READING && frame_count == '0;
    assign write_data = {debug_trig, raw_error_q, raw_frame_q.bits, clean_frame_q.bits};

    ////////////////////////////////////////
    // Frame windows
    ////////////////////////////////////////

    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            raw_window <= '0;
            clean_window <= '0;
            frame_count <= '0;
        end
        else
        begin
            raw_window <= {raw_window[FRAME_BITS-1:0], fast_command_in};
            clean_window <= {clean_window[FRAME_BITS-1:0], fast_command_out};
            frame_count <= frame_count + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Latched entry and trigger FSM
    ////////////////////////////////////////

    always_ff @(posedge fast_clock_in or negedge capture_rstn)
    begin
        if (!capture_rstn)
        begin
            raw_frame_q <= '0;
            clean_frame_q <= '0;
            raw_error_q <= 1'b0;
            capture_state <= FILLING;
            debug_trig <= 1'b0;
            wait_count <= '0;
            write_addr <= '0;
        end
        else
        begin
            if (frame_count == raw_offset)
            begin
                raw_frame_q <= raw_frame;
                raw_error_q <= raw_frame.fields.header != FRAME_HEADER;
            end
            if (frame_count == clean_offset)
                clean_frame_q <= clean_frame;

            if (write_enable)
                write_addr <= write_addr + 1'b1;    // Wraps over the buffer

            case (capture_state)
                FILLING:
                begin
                    if (raw_error_q)
                    begin
                        capture_state <= WAITING;
                        debug_trig <= 1'b1;
                    end
                end
                WAITING:
                begin
                    if (frame_count == '0)
                    begin
                        debug_trig <= 1'b0;
                        wait_count <= wait_count + 1'b1;
                    end
                    if (wait_count == post_delay)
                        capture_state <= READING;
                end
                default: ;                          // READING holds the buffer
            endcase
        end
    end

endmodule

// File: source/capture_memory.sv
`timescale 1ns/1ps

module capture_memory
    import fanout_pkg::*;
(
    input  logic                          fast_clock_in,
    input  logic                          write_enable,
    input  logic [CAPTURE_ADDR_BITS-1:0]  write_addr,
    input  logic [CAPTURE_WORD_BITS-1:0]  write_data,
    input  logic [CAPTURE_ADDR_BITS-1:0]  read_addr,
    output logic [CAPTURE_WORD_BITS-1:0]  read_data
);

    logic [CAPTURE_WORD_BITS-1:0] storage [CAPTURE_DEPTH];

    always_ff @(posedge fast_clock_in)
    begin
        if (write_enable)
            storage[write_addr] <= write_data;
        read_data <= storage[read_addr];    // One cycle read latency
    end

endmodule

// File: source/command_fanout.sv
`timescale 1ns/1ps

module command_fanout
    import fanout_pkg::*;
(
    input  logic               fast_clock_in,
    input  logic               arstn,
    input  logic               fast_command_out,
    output logic [NFANOUT-1:0] fanout_command
);

    logic [NFANOUT-1:0] line_value;     // Command copied to every line

    assign line_value = {NFANOUT{fast_command_out}} ^ INVERT_MASK;

    always_ff @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
            fanout_command <= '0;
        else
            fanout_command <= line_value;   // Registered at the output
    end

endmodule

// File: source/fast_control_fanout.sv
`timescale 1ns/1ps

module fast_control_fanout
    import fanout_pkg::*;
(
    input  logic                      fast_clock_in,
    input  logic                      arstn,
    input  logic                      fast_command_in,
    output logic                      fast_command_out,
    output logic [NFANOUT-1:0]        fanout_command,
    input  logic [REG_ADDR_BITS-1:0]  reg_addr,
    input  logic                      reg_write,
    input  logic                      reg_read,
    input  logic [REG_DATA_BITS-1:0]  reg_wdata,
    output logic [REG_DATA_BITS-1:0]  reg_rdata,
    output logic                      reg_ack,
    output logic                      debug_trig
);

    logic                         clean_enable;
    logic                         capture_restart;
    logic [FRAME_COUNT_BITS-1:0]  raw_offset;
    logic [FRAME_COUNT_BITS-1:0]  clean_offset;
    logic [REG_DELAY_BITS-1:0]    post_delay;
    capture_state_t               capture_state;
    logic                         write_enable;
    logic [CAPTURE_ADDR_BITS-1:0] write_addr;
    logic [CAPTURE_WORD_BITS-1:0] write_data;
    logic [CAPTURE_WORD_BITS-1:0] buffer_rdata;

    ////////////////////////////////////////
    // Command path
    ////////////////////////////////////////

    frame_cleaner cleaner0 (
        .fast_clock_in    (fast_clock_in),
        .arstn            (arstn),
        .fast_command_in  (fast_command_in),
        .clean_enable     (clean_enable),
        .fast_command_out (fast_command_out)
    );

    command_fanout fanout0 (
        .fast_clock_in    (fast_clock_in),
        .arstn            (arstn),
        .fast_command_out (fast_command_out),
        .fanout_command   (fanout_command)
    );

    ////////////////////////////////////////
    // Debug registers and capture
    ////////////////////////////////////////

    control_registers registers0 (
        .fast_clock_in   (fast_clock_in),
        .arstn           (arstn),
        .reg_addr        (reg_addr),
        .reg_write       (reg_write),
        .reg_read        (reg_read),
        .reg_wdata       (reg_wdata),
        .reg_rdata       (reg_rdata),
        .reg_ack         (reg_ack),
        .capture_state   (capture_state),
        .buffer_rdata    (buffer_rdata),
        .clean_enable    (clean_enable),
        .capture_restart (capture_restart),
        .raw_offset      (raw_offset),
        .clean_offset    (clean_offset),
        .post_delay      (post_delay)
    );

    frame_capture capture0 (
        .fast_clock_in    (fast_clock_in),
        .arstn            (arstn),
        .capture_restart  (capture_restart),
        .fast_command_in  (fast_command_in),
        .fast_command_out (fast_command_out),
        .raw_offset       (raw_offset),
        .clean_offset     (clean_offset),
        .post_delay       (post_delay),
        .capture_state    (capture_state),
        .debug_trig       (debug_trig),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_data       (write_data)
    );

    capture_memory memory0 (
        .fast_clock_in (fast_clock_in),
        .write_enable  (write_enable),
        .write_addr    (write_addr),
        .write_data    (write_data),
        .read_addr     (reg_addr[CAPTURE_ADDR_BITS-1:0]),  // Buffer entry from the register port
        .read_data     (buffer_rdata)
    );

endmodule

// File: bench/tb_fast_control_fanout.sv
`timescale 1ns/1ps

module tb_fast_control_fanout
    import fanout_pkg::*;
();

    localparam int CLOCK_PERIOD = 40;
    localparam int TOTAL_FRAMES = 700;                  // Upper bound on the stream length
    localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * FRAME_BITS + 2000;

    logic                     fast_clock_in;
    logic                     arstn;
    logic                     fast_command_in;
    logic                     fast_command_out;
    logic [NFANOUT-1:0]       fanout_command;
    logic [REG_ADDR_BITS-1:0] reg_addr;
    logic                     reg_write;
    logic                     reg_read;
    logic [REG_DATA_BITS-1:0] reg_wdata;
    logic [REG_DATA_BITS-1:0] reg_rdata;
    logic                     reg_ack;
    logic                     debug_trig;

    logic [15:0] lfsr = 16'd65017;
    int          value_errors = 0;
    int          other_errors = 0;
    logic        stream_stop = 1'b0;
    logic        reset_done = 1'b0;

    // Reference model state
    logic                          m_resync, m_cen, m_ack, m_restart, m_err, m_trig;
    logic [FRAME_BITS:0]           m_win, m_osh, m_rwin, m_cwin;
    logic [FRAME_COUNT_BITS-1:0]   m_bit, m_lpos, m_fc, m_raw_off, m_clean_off;
    logic [LOCK_BITS-1:0]          m_lcnt;
    logic [NFANOUT-1:0]            m_lines;
    logic [REG_DATA_BITS-1:0]      m_rdata;
    logic [REG_DELAY_BITS-1:0]     m_delay, m_wait;
    logic [FRAME_BITS-1:0]         m_rawq, m_cleanq;
    logic [CAPTURE_ADDR_BITS-1:0]  m_waddr;
    capture_state_t                m_state;
    logic [CAPTURE_WORD_BITS-1:0]  m_mem [CAPTURE_DEPTH];

    fast_control_fanout dut0 (.*);

    initial
    begin
        fast_clock_in = 1'b0;
        forever #(CLOCK_PERIOD/2) fast_clock_in = ~fast_clock_in;
    end

    ////////////////////////////////////////
    // Random bits and compare tasks
    ////////////////////////////////////////

    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;   // Galois step
            value = {value[6:0], lfsr[0]};
        end
        return value;
    endfunction

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("[FAIL] %s expected %b actual %b at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_lines(input string name, input logic [NFANOUT-1:0] expected,
                               input logic [NFANOUT-1:0] actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("[FAIL] %s expected %b actual %b at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_word(input string name, input logic [REG_DATA_BITS-1:0] expected,
                              input logic [REG_DATA_BITS-1:0] actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    task automatic step_model();
        logic [FRAME_BITS-1:0]     cand;
        logic [REG_INDEX_BITS-1:0] index;
        logic                      match, shifted, at_lock, restart_old, restart_new;
        logic [REG_DELAY_BITS-1:0] wait_old;
        logic                      err_old;
        cand = m_win[FRAME_BITS:1];
        index = reg_addr[REG_INDEX_BITS-1:0];
        match = cand[7:5] == 3'b110 && cand[0];
        shifted = m_win[7:5] == 3'b110 || m_win[6:4] == 3'b110;
        at_lock = m_bit == m_lpos;
        restart_old = m_restart;
        m_ack = reg_write || reg_read;
        if (reg_read)
        begin
            if (reg_addr[REG_BUFFER_BIT])
                m_rdata = {14'b0, m_mem[reg_addr[7:0]]};
            else if (index == 0)
                m_rdata = {m_state, 29'b0, m_restart};
            else if (index == 1)
                m_rdata = {26'b0, m_clean_off, m_raw_off};
            else if (index == 2)
                m_rdata = {24'b0, m_delay};
            else
                m_rdata = {31'b0, m_cen};
        end
        for (int i = 0; i < NFANOUT; i++)
            m_lines[i] = INVERT_MASK[i] ? !m_osh[FRAME_BITS] : m_osh[FRAME_BITS];

        // Capture engine
        if (m_state != READING && m_fc == 0)
        begin
            m_mem[m_waddr] = {m_trig, m_err, m_rawq, m_cleanq};
            if (!restart_old)
                m_waddr++;
        end
        if (!restart_old)
        begin
            wait_old = m_wait;
            err_old = m_err;
            if (m_fc == m_raw_off)
            begin
                m_rawq = m_rwin[FRAME_BITS:1];
                m_err = m_rwin[FRAME_BITS -: 3] != 3'b110;
            end
            if (m_fc == m_clean_off)
                m_cleanq = m_cwin[FRAME_BITS:1];
            if (m_state == FILLING && err_old)
            begin
                m_state = WAITING;
                m_trig = 1'b1;
            end
            else if (m_state == WAITING)
            begin
                if (m_fc == 0)
                begin
                    m_trig = 1'b0;
                    m_wait++;
                end
                if (wait_old == m_delay)
                    m_state = READING;
            end
        end
        m_rwin = {m_rwin[FRAME_BITS-1:0], fast_command_in};
        m_cwin = {m_cwin[FRAME_BITS-1:0], m_osh[FRAME_BITS]};
        m_fc++;

        // Cleaner lock and output frame
        if (m_lcnt == 0)
        begin
            if (match)
            begin
                m_lpos = m_bit;
                m_lcnt = 1;
            end
        end
        else if (at_lock)
            m_lcnt = !match ? m_lcnt - 1'b1 : (m_lcnt == 63 ? m_lcnt : m_lcnt + 1'b1);
        else if (match)
            m_lcnt--;
        if (at_lock)
            m_osh = {m_osh[FRAME_BITS-1], (m_cen && (!match || shifted)) ? IDLE_FRAME : cand};
        else
            m_osh = {m_osh[FRAME_BITS-1:0], 1'b0};
        m_bit++;
        m_win = {m_win[FRAME_BITS-1:0], m_resync};
        m_resync = fast_command_in;

        // Register writes
        restart_new = 1'b0;
        if (reg_write && !reg_addr[REG_BUFFER_BIT])
        begin
            if (index == 0)
                restart_new = reg_wdata[0];
            else if (index == 1)
                {m_clean_off, m_raw_off} = reg_wdata[5:0];
            else if (index == 2)
                m_delay = reg_wdata[7:0];
            else
                m_cen = reg_wdata[0];
        end
        m_restart = restart_new;
        if (restart_old || restart_new)
            clear_capture();
    endtask

    task automatic clear_capture();
        m_rawq = '0;
        m_cleanq = '0;
        m_err = 1'b0;
        m_state = FILLING;
        m_trig = 1'b0;
        m_wait = '0;
        m_waddr = '0;
    endtask

    always @(posedge fast_clock_in or negedge arstn)
    begin
        if (!arstn)
        begin
            {m_resync, m_ack, m_restart, m_win, m_osh, m_rwin, m_cwin} = '0;
            {m_bit, m_lpos, m_fc, m_raw_off, m_clean_off, m_lcnt, m_lines, m_rdata} = '0;
            m_cen = REG_CLEAN_ENABLE_DEFAULT;
            m_delay = REG_DELAY_DEFAULT;
            clear_capture();
        end
        else
            step_model();
    end

    always @(negedge fast_clock_in)
    begin
        if (arstn)
        begin
            check_bit("fast_command_out", m_osh[FRAME_BITS], fast_command_out);
            check_lines("fanout_command", m_lines, fanout_command);
            check_bit("debug_trig", m_trig, debug_trig);
            check_bit("reg_ack", m_ack, reg_ack);
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic send_frame();
        logic [FRAME_BITS-1:0] frame;
        logic [7:0]            payload;
        logic [7:0]            damage_pos;
        payload = random_bits(4);
        frame = {3'b110, payload[3:0], 1'b1};
        if (random_bits(3) == 8'd7)
        begin
            damage_pos = random_bits(2);                    // 0 to 2 header, 3 stop
            frame[damage_pos == 3 ? 0 : 5 + damage_pos] ^= 1'b1;
        end
        for (int i = FRAME_BITS - 1; i >= 0; i--)
        begin
            @(posedge fast_clock_in);
            fast_command_in <= frame[i];
        end
    endtask

    initial
    begin
        wait (reset_done);
        while (!stream_stop)
            send_frame();
    end

    task automatic bus_write(input logic [REG_ADDR_BITS-1:0] addr,
                             input logic [REG_DATA_BITS-1:0] data);
        @(posedge fast_clock_in);
        reg_write <= 1'b1;
        reg_addr <= addr;
        reg_wdata <= data;
        @(posedge fast_clock_in);
        reg_write <= 1'b0;
    endtask

    task automatic bus_read(input logic [REG_ADDR_BITS-1:0] addr,
                            output logic [REG_DATA_BITS-1:0] data);
        @(posedge fast_clock_in);
        reg_read <= 1'b1;
        reg_addr <= addr;
        @(posedge fast_clock_in);
        reg_read <= 1'b0;
        @(negedge fast_clock_in);
        check_bit("read ack", 1'b1, reg_ack);
        check_word("read data", m_rdata, reg_rdata);
        data = reg_rdata;
    endtask

    task automatic wait_for_reading();
        logic [REG_DATA_BITS-1:0] data;
        int                       tries;
        tries = 0;
        do
        begin
            bus_read(10'(REG_CONTROL), data);
            tries++;
        end
        while (data[31:30] != READING && tries < 600);
        if (data[31:30] != READING)
        begin
            other_errors++;
            $display("Capture never reached the READING state");
        end
    endtask

    task automatic wait_for_trigger();
        int cycles;
        cycles = 0;
        @(negedge fast_clock_in);
        while (!debug_trig && cycles < 800)
        begin
            @(negedge fast_clock_in);
            cycles++;
        end
        if (!debug_trig)
        begin
            other_errors++;
            $display("No damaged frame raised the debug trigger");
        end
    endtask

    task automatic read_buffer(input int entries);
        logic [REG_DATA_BITS-1:0] data;
        for (int i = 0; i < entries; i++)
            bus_read(10'h200 | 10'(i), data);
    endtask

    initial
    begin
        logic [REG_DATA_BITS-1:0] data;
        arstn = 1'b0;
        fast_command_in = 1'b0;
        reg_addr = '0;
        reg_write = 1'b0;
        reg_read = 1'b0;
        reg_wdata = '0;
        repeat (2) @(posedge fast_clock_in);
        arstn <= 1'b1;
        reset_done = 1'b1;

        bus_read(10'(REG_DELAY), data);
        check_word("default delay", 32'd100, data);
        bus_read(10'(REG_CLEAN_ENABLE), data);
        check_word("default clean enable", 32'd1, data);
        bus_read(10'(REG_OFFSETS), data);
        check_word("default offsets", 32'd0, data);

        bus_write(10'(REG_OFFSETS), 32'b110010);            // Raw 2 and clean 6 match the frame phase
        bus_write(10'(REG_DELAY), 32'd20);
        bus_write(10'(REG_CONTROL), 32'd1);                 // Restart capture
        bus_read(10'(REG_CONTROL), data);
        check_word("state after restart", 32'd0, data);
        wait_for_trigger();
        wait_for_reading();
        read_buffer(CAPTURE_DEPTH);

        bus_write(10'(REG_CLEAN_ENABLE), 32'd0);
        bus_write(10'h3FF, 32'hFFFF_FFFF);                  // Buffer range write is ignored
        bus_write(10'(REG_CONTROL), 32'd1);
        bus_read(10'(REG_CONTROL), data);
        check_word("state after restart", 32'd0, data);
        wait_for_trigger();
        wait_for_reading();
        read_buffer(64);

        stream_stop = 1'b1;
        repeat (16) @(posedge fast_clock_in);
        $display("Checks done with %0d value errors and %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Checks done with %0d value errors and %0d other errors",
                 value_errors, other_errors + 1);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: project.f
source/fanout_pkg.sv
source/frame_cleaner.sv
source/control_registers.sv
source/frame_capture.sv
source/capture_memory.sv
source/command_fanout.sv
source/fast_control_fanout.sv
bench/tb_fast_control_fanout.sv
